/* opto_stim_pkg.sv */
package opto_stim_pkg;

  // ----------------------------------------
  // geometry of the s-bit word
  // ----------------------------------------

  localparam int N_VFATS     = 8;  // vfats driven by the stimulus
  localparam int TU_PER_VFAT = 8;  // trigger units per vfat
  localparam int SBIT_W      = N_VFATS * TU_PER_VFAT;  // 64 s-bits total

  // ----------------------------------------
  // bunch-crossing timing
  // ----------------------------------------

  localparam int BX_CNT_W   = 6;   // 64-crossing pattern period
  localparam int BC0_PERIOD = 32;  // power of two, divides 2**BX_CNT_W
  localparam int BC0_W      = $clog2(BC0_PERIOD);  // counter bits compared for bc0

  // link request timing
  localparam int STARTUP_CYCLES = 60;  // crossings before the first request
  localparam int HOLDOFF_CYCLES = 7;   // quiet crossings after each busy
  localparam int STARTUP_W      = $clog2(STARTUP_CYCLES + 1);
  localparam int HOLDOFF_W      = $clog2(HOLDOFF_CYCLES + 1);

  // ----------------------------------------
  // stimulus constants
  // ----------------------------------------

  localparam logic [SBIT_W-1:0] PAT_EVEN = 64'h00000000000000fe;  // even crossing hits
  localparam logic [SBIT_W-1:0] PAT_ODD  = 64'h0000000000000001;  // odd crossing hits

  // per-vfat polarity swap of the board lines, vfat 0 in the low byte
  localparam logic [SBIT_W-1:0] SBIT_INVERT = {
    8'h32,  // vfat 7
    8'h08,  // vfat 6
    8'hbd,  // vfat 5
    8'h2d,  // vfat 4
    8'he7,  // vfat 3
    8'h46,  // vfat 2
    8'h67,  // vfat 1
    8'h45   // vfat 0
  };

  localparam logic [31:0] REQ_DATA_INIT = 32'hAAAAAAAA;  // first request payload

  // ----------------------------------------
  // types
  // ----------------------------------------

  // same 64 bits, seen flat or per vfat
  typedef union packed {
    logic [SBIT_W-1:0]                      flat;
    logic [N_VFATS-1:0][TU_PER_VFAT-1:0]    vfat;  // vfat[i] = trigger units of vfat i
  } sbit_word_u;

  // crossing phase, one bit each
  typedef struct packed {
    logic bc0;        // one crossing every BC0_PERIOD
    logic even_slot;  // crossing that carries PAT_EVEN
    logic odd_slot;   // crossing that carries PAT_ODD
  } bx_phase_t;

  // s-bits as seen on the board pins
  typedef struct packed {
    logic [SBIT_W-1:0] word;     // after polarity inversion
    logic              trigger;  // raw pattern had a hit
  } sbit_out_t;

  // register-write request towards the link tx
  typedef struct packed {
    logic        valid;  // level, sampled every crossing
    logic [31:0] data;
  } link_req_t;

endpackage

/* bx_phase_decode.sv */
`timescale 1ns/100ps

module bx_phase_decode
  import opto_stim_pkg::*;
(
  input  logic      clk40,
  input  logic      rst_n_i,
  output bx_phase_t phase_o
);

  // ----------------------------------------
  // bunch-crossing counter
  // ----------------------------------------

  logic [BX_CNT_W-1:0] bx_cnt;  // free running, wraps every 64 crossings
  logic                bc0_q;   // registered orbit marker
  logic                bc0_hit; // last crossing of the bc0 period

  always_ff @(posedge clk40) begin
    if (!rst_n_i) begin
      bx_cnt <= '0;
    end else begin
      bx_cnt <= bx_cnt + 1'b1;  // wrap is intentional
    end
  end

  // only the low bits matter, period divides the counter range
  assign bc0_hit = (bx_cnt[BC0_W-1:0] == BC0_W'(BC0_PERIOD - 1));

  // bc0 lands one edge after the counter shows 31, 63
  always_ff @(posedge clk40) begin
    if (!rst_n_i) begin
      bc0_q <= 1'b0;
    end else begin
      bc0_q <= bc0_hit;
    end
  end

  // ----------------------------------------
  // pattern slot decode
  // ----------------------------------------

  // slots decode straight from the count, so even is up right out of reset
  assign phase_o.bc0       = bc0_q;
  assign phase_o.even_slot = (bx_cnt == BX_CNT_W'(0));  // slot 0
  assign phase_o.odd_slot  = (bx_cnt == BX_CNT_W'(1));  // slot 1

endmodule

/* sbit_pattern_gen.sv */
`timescale 1ns/100ps

module sbit_pattern_gen
  import opto_stim_pkg::*;
(
  input  logic      clk40,
  input  logic      rst_n_i,
  input  bx_phase_t phase_i,
  output sbit_out_t sbit_o
);

  sbit_word_u raw_pat;   // hits as the vfats would send them
  sbit_word_u inv_pat;   // what the fpga pins actually see
  logic       raw_hit;   // any trigger unit fired

  // ----------------------------------------
  // slot select
  // ----------------------------------------

  // even and odd crossings carry different patterns to exercise both encoders
  always_comb begin
    if (phase_i.even_slot) begin
      raw_pat.flat = PAT_EVEN;
    end else if (phase_i.odd_slot) begin
      raw_pat.flat = PAT_ODD;
    end else begin
      raw_pat.flat = '0;  // idle, keeps latency clear
    end
  end

  assign raw_hit = |raw_pat.flat;

  // ----------------------------------------
  // per-vfat inversion
  // ----------------------------------------

  // swapped p/n pairs flip the line, done one vfat byte at a time
  always_comb begin
    for (int v = 0; v < N_VFATS; v++) begin
      inv_pat.vfat[v] = raw_pat.vfat[v] ^ SBIT_INVERT[v*TU_PER_VFAT +: TU_PER_VFAT];
    end
  end

  // ----------------------------------------
  // output register
  // ----------------------------------------

  // idle word is the mask itself, an all-zero pattern inverted
  always_ff @(posedge clk40) begin
    if (!rst_n_i) begin
      sbit_o.word    <= SBIT_INVERT;
      sbit_o.trigger <= 1'b0;
    end else begin
      sbit_o.word    <= inv_pat.flat;
      sbit_o.trigger <= raw_hit;  // inverted lines still carry the hits
    end
  end

endmodule

/* link_request_gen.sv */
`timescale 1ns/100ps

module link_request_gen
  import opto_stim_pkg::*;
(
  input  logic      clk40,
  input  logic      rst_n_i,
  input  logic      tx_busy_i,  // link tx is serializing
  output link_req_t req_o
);

  logic [STARTUP_W-1:0] startup_cnt;   // saturates at STARTUP_CYCLES
  logic                 startup_done;
  logic [HOLDOFF_W-1:0] holdoff;       // crossings left before the next request
  logic                 holdoff_clr;   // no holdoff pending
  logic [31:0]          req_data;

  // ----------------------------------------
  // startup hold
  // ----------------------------------------

  // give the link time to lock before the first write
  always_ff @(posedge clk40) begin
    if (!rst_n_i) begin
      startup_cnt <= '0;
    end else if (!startup_done) begin
      startup_cnt <= startup_cnt + 1'b1;
    end
  end

  assign startup_done = (startup_cnt == STARTUP_W'(STARTUP_CYCLES));

  // ----------------------------------------
  // busy holdoff
  // ----------------------------------------

  always_ff @(posedge clk40) begin
    if (!rst_n_i) begin
      holdoff <= '0;
    end else if (tx_busy_i) begin
      holdoff <= HOLDOFF_W'(HOLDOFF_CYCLES);  // reload on every busy crossing
    end else if (!holdoff_clr) begin
      holdoff <= holdoff - 1'b1;
    end
  end

  assign holdoff_clr = (holdoff == '0);

  // ----------------------------------------
  // request data
  // ----------------------------------------

  // flip the payload each free crossing, so consecutive writes differ
  always_ff @(posedge clk40) begin
    if (!rst_n_i) begin
      req_data <= REQ_DATA_INIT;
    end else if (holdoff_clr) begin
      req_data <= ~req_data;
    end
  end

  // valid only from registers, busy reaches it one edge later
  assign req_o.valid = startup_done & holdoff_clr;
  assign req_o.data  = req_data;

endmodule

/* opto_stim_top.sv */
`timescale 1ns/100ps

module opto_stim_top
  import opto_stim_pkg::*;
(
  input  logic      clk40,
  input  logic      rst_n_i,
  input  logic      tx_busy_i,  // from the external link tx
  output bx_phase_t phase_o,
  output sbit_out_t sbit_o,
  output link_req_t req_o
);

  bx_phase_t phase;  // crossing phase, shared by pattern gen and the port

  // ----------------------------------------
  // decode: crossing phase
  // ----------------------------------------

  bx_phase_decode u_bx_phase_decode (
    .clk40   (clk40),
    .rst_n_i (rst_n_i),
    .phase_o (phase)
  );

  assign phase_o = phase;

  // ----------------------------------------
  // execute: s-bit pattern
  // ----------------------------------------

  sbit_pattern_gen u_sbit_pattern_gen (
    .clk40   (clk40),
    .rst_n_i (rst_n_i),
    .phase_i (phase),
    .sbit_o  (sbit_o)   // one crossing behind the slot
  );

  // ----------------------------------------
  // result: link write requests
  // ----------------------------------------

  // no handshake, valid is a plain level
  link_request_gen u_link_request_gen (
    .clk40     (clk40),
    .rst_n_i   (rst_n_i),
    .tx_busy_i (tx_busy_i),
    .req_o     (req_o)
  );

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen (
  output logic clk40_o,  // bunch-crossing clock
  output logic rst_n_o   // synchronous, active low
);

  localparam int HALF_PERIOD = 50;  // ns, 100 ns period
  localparam int RESET_EDGES = 2;   // rising edges with reset low

  initial begin
    clk40_o = 1'b0;
    forever #(HALF_PERIOD) clk40_o = ~clk40_o;
  end

  // release on a rising edge so the next edge is the first active one
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_EDGES) @(posedge clk40_o);
    rst_n_o <= 1'b1;
  end

endmodule

/* opto_stim_sva.sv */
`timescale 1ns/100ps

module opto_stim_sva
  import opto_stim_pkg::*;
(
  input logic      clk40,
  input logic      rst_n_i,
  input logic      tx_busy_i,  // busy level from the link tx
  input bx_phase_t phase_i,
  input sbit_out_t sbit_i,
  input link_req_t req_i
);

  int fail_cnt = 0;  // assertion failures so far

  // ----------------------------------------
  // properties
  // ----------------------------------------

  // bc0 marks one crossing per period, never two in a row
  a_bc0_single : assert property (
    @(posedge clk40) disable iff (!rst_n_i) phase_i.bc0 |=> !phase_i.bc0
  ) else begin
    $error("bc0 high in two consecutive crossings");
    fail_cnt++;
  end

  // a busy crossing keeps the request quiet for the whole holdoff
  a_valid_holdoff : assert property (
    @(posedge clk40) disable iff (!rst_n_i)
      tx_busy_i |=> (!req_i.valid) [*HOLDOFF_CYCLES]
  ) else begin
    $error("request valid while the busy holdoff is running");
    fail_cnt++;
  end

  // a hit has to show up on the pins, one crossing after its slot
  a_trigger_word : assert property (
    @(posedge clk40) disable iff (!rst_n_i)
      sbit_i.trigger |-> (sbit_i.word != SBIT_INVERT)
                         && $past(phase_i.even_slot || phase_i.odd_slot)
  ) else begin
    $error("trigger high with an idle s-bit word or outside a pattern slot");
    fail_cnt++;
  end

endmodule

/* opto_stim_tb.sv */
`timescale 1ns/100ps

module opto_stim_tb
  import opto_stim_pkg::*;
();

  localparam int LAST_EDGE      = 200;            // table length in crossings
  localparam int TIMEOUT_CYCLES = 2 * LAST_EDGE;  // generous margin over the table
  localparam int N_TESTS        = 6;              // reset check plus five windows
  localparam int PAT_PERIOD     = 2 ** BX_CNT_W;  // 64 crossings

  // one row per crossing, expected values after that edge
  typedef struct packed {
    logic [8:0]  edge_n;   // edge number after reset release
    logic        busy;     // busy level sampled at this edge
    logic        bc0;
    logic        trigger;
    logic [63:0] word;
    logic        valid;
    logic        toggle;   // data flips on this edge
  } row_t;

  logic      clk40;
  logic      rst_n;
  logic      tx_busy;
  bx_phase_t phase;
  sbit_out_t sbit;
  link_req_t req;

  row_t        table_q [1:LAST_EDGE];
  int          busy_edges [$];       // edges where busy is seen high
  string       test_name [N_TESTS];
  int          test_end [N_TESTS];   // last edge of each window
  int          check_cnt = 0;
  int          err_cnt = 0;
  int          test_err = 0;         // errors in the running window
  int          fail_tests = 0;
  int          cyc = 0;              // timeout counter
  int          k2;                   // random second busy edge
  int          n;
  int          t;
  logic [31:0] exp_data;             // model of the alternating payload

  // ----------------------------------------
  // clock, DUT, assertions
  // ----------------------------------------

  tb_clock_gen u_clk (
    .clk40_o (clk40),
    .rst_n_o (rst_n)
  );

  opto_stim_top uut (
    .clk40     (clk40),
    .rst_n_i   (rst_n),
    .tx_busy_i (tx_busy),
    .phase_o   (phase),
    .sbit_o    (sbit),
    .req_o     (req)
  );

  bind opto_stim_top opto_stim_sva u_sva (
    .clk40     (clk40),
    .rst_n_i   (rst_n_i),
    .tx_busy_i (tx_busy_i),
    .phase_i   (phase_o),
    .sbit_i    (sbit_o),
    .req_i     (req_o)
  );

  // ----------------------------------------
  // expected values
  // ----------------------------------------

  // holdoff still set after edge m, busy at k covers k .. k+6
  function automatic logic in_holdoff(input int m);
    logic hit;
    hit = 1'b0;
    foreach (busy_edges[i]) begin
      if (m >= busy_edges[i] && m <= busy_edges[i] + HOLDOFF_CYCLES - 1) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  task automatic fill_table();
    row_t r;
    int   p;  // position in the pattern period
    for (int e = 1; e <= LAST_EDGE; e++) begin
      p         = e % PAT_PERIOD;
      r.edge_n  = 9'(e);
      r.busy    = 1'b0;
      foreach (busy_edges[i]) begin
        if (busy_edges[i] == e) begin
          r.busy = 1'b1;
        end
      end
      r.bc0     = (e % BC0_PERIOD == 0);       // one edge after count 31, 63
      r.trigger = (p == 1) || (p == 2);        // slot shows one edge later
      if (p == 1) begin
        r.word = PAT_EVEN ^ SBIT_INVERT;
      end else if (p == 2) begin
        r.word = PAT_ODD ^ SBIT_INVERT;
      end else begin
        r.word = SBIT_INVERT;                  // idle word is the mask
      end
      r.valid   = (e >= STARTUP_CYCLES) && !in_holdoff(e);
      r.toggle  = !in_holdoff(e - 1);          // flips while holdoff was clear
      table_q[e] = r;
    end
  endtask

  task automatic report_mismatch(input int e, input string sig, input logic [63:0] exp_v,
                                 input logic [63:0] got_v);
    $display("Error at %0t ns (edge %0d): %s expected %h, got %h",
             $time, e, sig, exp_v, got_v);
    err_cnt++;
    test_err++;
  endtask

  // ----------------------------------------
  // checks
  // ----------------------------------------

  task automatic check_reset();
    check_cnt++;
    if (phase !== 3'b010) report_mismatch(0, "phase_o", 64'(3'b010), 64'(phase));  // even only
    if (sbit.word !== SBIT_INVERT) report_mismatch(0, "sbit_o.word", SBIT_INVERT, sbit.word);
    if (sbit.trigger !== 1'b0) report_mismatch(0, "sbit_o.trigger", 64'(0), 64'(sbit.trigger));
    if (req.valid !== 1'b0) report_mismatch(0, "req_o.valid", 64'(0), 64'(req.valid));
    if (req.data !== REQ_DATA_INIT) begin
      report_mismatch(0, "req_o.data", 64'(REQ_DATA_INIT), 64'(req.data));
    end
  endtask

  task automatic check_row(input row_t r);
    int e;
    e = int'(r.edge_n);
    if (r.toggle) begin
      exp_data = ~exp_data;
    end
    check_cnt++;
    if (phase.bc0 !== r.bc0) report_mismatch(e, "phase_o.bc0", 64'(r.bc0), 64'(phase.bc0));
    if (sbit.trigger !== r.trigger) begin
      report_mismatch(e, "sbit_o.trigger", 64'(r.trigger), 64'(sbit.trigger));
    end
    if (sbit.word !== r.word) report_mismatch(e, "sbit_o.word", r.word, sbit.word);
    if (req.valid !== r.valid) begin
      report_mismatch(e, "req_o.valid", 64'(r.valid), 64'(req.valid));
    end
    if (req.data !== exp_data) report_mismatch(e, "req_o.data", 64'(exp_data), 64'(req.data));
  endtask

  task automatic close_test(input int idx, input int first, input int last);
    if (test_err == 0) begin
      $display("test %0d %s, edges %0d to %0d: ok", idx, test_name[idx], first, last);
    end else begin
      $display("test %0d %s, edges %0d to %0d: %0d errors",
               idx, test_name[idx], first, last, test_err);
      fail_tests++;
    end
    test_err = 0;
  endtask

  // ----------------------------------------
  // run
  // ----------------------------------------

  initial begin
    tx_busy  = 1'b0;
    void'($urandom(32'h5d63f3f7));      // seeds the generator once
    k2       = 101 + ($urandom % 50);   // second busy pulse, 101 .. 150
    busy_edges.push_back(80);
    busy_edges.push_back(81);           // back to back, window restarts
    busy_edges.push_back(k2);
    test_name[0] = "reset values";
    test_name[1] = "startup hold";
    test_name[2] = "first requests";
    test_name[3] = "busy holdoff";
    test_name[4] = "random busy holdoff";
    test_name[5] = "steady run";
    test_end[0]  = 0;
    test_end[1]  = STARTUP_CYCLES - 1;
    test_end[2]  = 79;
    test_end[3]  = 99;
    test_end[4]  = k2 + 9;
    test_end[5]  = LAST_EDGE;
    fill_table();
    exp_data = REQ_DATA_INIT;
    $display("second busy pulse at edge %0d", k2);

    // wait out reset, the next rising edge is edge 1
    @(negedge clk40);
    while (!rst_n) begin
      @(negedge clk40);
    end
    check_reset();
    close_test(0, 0, 0);

    t = 1;
    for (n = 1; n <= LAST_EDGE; n++) begin
      @(posedge clk40);                        // edge n
      if (n < LAST_EDGE) begin
        tx_busy <= table_q[n + 1].busy;        // sampled at edge n+1
      end else begin
        tx_busy <= 1'b0;
      end
      @(negedge clk40);                        // outputs settled
      check_row(table_q[n]);
      if (n == test_end[t]) begin
        close_test(t, test_end[t - 1] + 1, n);
        t++;
      end
    end

    $display("%0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
             N_TESTS, fail_tests, check_cnt, err_cnt, uut.u_sva.fail_cnt);
    if (err_cnt == 0 && uut.u_sva.fail_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // hard stop if the run hangs
  always @(posedge clk40) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("STATUS: FAIL");
      $finish;
    end
  end

endmodule

/* list.f */
opto_stim_pkg.sv
bx_phase_decode.sv
sbit_pattern_gen.sv
link_request_gen.sv
opto_stim_top.sv
tb_clock_gen.sv
opto_stim_sva.sv
opto_stim_tb.sv

/* Bender.yml */
package:
  name: opto_stim

sources:
  # rtl, package first
  - opto_stim_pkg.sv
  - bx_phase_decode.sv
  - sbit_pattern_gen.sv
  - link_request_gen.sv
  - opto_stim_top.sv
  # testbench
  - target: simulation
    files:
      - tb_clock_gen.sv
      - opto_stim_sva.sv
      - opto_stim_tb.sv
